/* flist.f */
+incdir+test
source/bp_pkg.sv
source/branch_classifier.sv
source/pattern_table.sv
source/inflight_queue.sv
source/branch_ctrl.sv
source/branch_stats.sv
source/bp_top.sv
test/tb_bp_top.sv

/* run.sh */
#!/bin/sh
# Build and run the branch predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_bp_top -f flist.f -o Vtb_bp_top

./obj_dir/Vtb_bp_top 2>&1 | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
grep -q "STATUS: PASS" sim.log

/* source/bp_pkg.sv */
package bp_pkg;

  // Widths that carry a meaning
  typedef logic [31:0] addr_t;   // Fetch PC, byte address
  typedef logic [31:0] instr_t;  // Raw RV32I instruction word
  typedef logic [1:0]  ctr_t;    // Two-bit saturating counter
  typedef logic [15:0] stat_t;   // Event count

  // Counter encodings, upper bit is the predicted direction
  localparam ctr_t CTR_MIN  = 2'd0;  // Strongly not taken
  localparam ctr_t CTR_INIT = 2'd1;  // Weakly not taken
  localparam ctr_t CTR_MAX  = 2'd3;  // Strongly taken

  // RV32I opcodes of interest
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;  // Indirect, not predicted here

  typedef enum logic [1:0] {
    BR_NONE = 2'd0,
    BR_COND = 2'd1,
    BR_JAL  = 2'd2
  } br_kind_e;

  typedef enum logic {
    ST_RUN      = 1'b0,
    ST_REDIRECT = 1'b1  // One bubble after a miss
  } ctrl_state_e;

  // One queued prediction
  typedef struct packed {
    logic        is_cond;     // Conditional branch, trains the table
    logic        pred_taken;  // Direction handed to fetch
    logic [15:0] tbl_idx;     // Low IDX_BITS used
  } pred_entry_t;

  // Resolve event of the oldest branch
  typedef struct packed {
    logic br;     // Branch resolved this cycle
    logic miss;   // Prediction was wrong
    logic taken;  // Actual outcome
  } res_event_t;

endpackage : bp_pkg

/* source/bp_top.sv */
module bp_top #(
  parameter int IDX_BITS    = 6,
  parameter int HIST_BITS   = 4,
  parameter int QUEUE_DEPTH = 4
) (
  input  logic           clk_i,
  input  logic           rst_i,
  // Fetch side
  input  logic           fetch_vld_i,
  input  bp_pkg::addr_t  fetch_pc_i,
  input  bp_pkg::instr_t instr_i,
  output logic           pred_taken_o,
  output logic           stall_o,
  output bp_pkg::instr_t instr_o,
  // Resolve side, oldest branch
  input  logic           res_vld_i,
  input  logic           res_taken_i,
  // Status
  output logic           br_instr_o,
  output logic           br_miss_o,
  output bp_pkg::stat_t  br_count_o,
  output bp_pkg::stat_t  miss_count_o
);

  bp_pkg::br_kind_e    kind;
  bp_pkg::pred_entry_t fetch_entry;  // Prediction of this fetch
  bp_pkg::pred_entry_t head_entry;   // Oldest in flight
  bp_pkg::res_event_t  res_event;
  logic                push;
  logic                pop;
  logic                flush;
  logic                q_empty;
  logic                q_full;

  branch_classifier u_classifier (
    .fetch_vld_i (fetch_vld_i),
    .instr_i     (instr_i),
    .kind_o      (kind)
  );

  pattern_table #(.IDX_BITS(IDX_BITS), .HIST_BITS(HIST_BITS)) u_table (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .fetch_pc_i (fetch_pc_i),
    .kind_i     (kind),
    .entry_o    (fetch_entry),
    .upd_i      (res_event),
    .upd_idx_i  (head_entry.tbl_idx),  // Index saved at fetch
    .upd_cond_i (head_entry.is_cond)
  );

  inflight_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .push_i       (push),
    .push_entry_i (fetch_entry),
    .pop_i        (pop),
    .flush_i      (flush),
    .head_o       (head_entry),
    .empty_o      (q_empty),
    .full_o       (q_full)
  );

  branch_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .kind_i      (kind),
    .res_vld_i   (res_vld_i),
    .res_taken_i (res_taken_i),
    .head_i      (head_entry),
    .empty_i     (q_empty),
    .full_i      (q_full),
    .push_o      (push),
    .pop_o       (pop),
    .flush_o     (flush),
    .res_o       (res_event),
    .stall_o     (stall_o),
    .br_instr_o  (br_instr_o),
    .br_miss_o   (br_miss_o)
  );

  branch_stats u_stats (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .res_i        (res_event),
    .br_count_o   (br_count_o),
    .miss_count_o (miss_count_o)
  );

  assign pred_taken_o = fetch_entry.pred_taken;  // Driven even during redirect

  // Fetched instruction, one cycle behind
  always_ff @(posedge clk_i) begin
    if (rst_i) instr_o <= '0;
    else       instr_o <= instr_i;
  end

endmodule : bp_top

/* source/branch_classifier.sv */
module branch_classifier (
  input  logic             fetch_vld_i,
  input  bp_pkg::instr_t   instr_i,
  output bp_pkg::br_kind_e kind_o
);

  logic [6:0] opcode;

  assign opcode = instr_i[6:0];

  always_comb begin
    kind_o = bp_pkg::BR_NONE;
    if (fetch_vld_i) begin  // Nothing to classify without a fetch
      case (opcode)
        bp_pkg::OPC_BRANCH: kind_o = bp_pkg::BR_COND;  // BEQ .. BGEU
        bp_pkg::OPC_JAL:    kind_o = bp_pkg::BR_JAL;
        // JALR target comes from a register, left to the core
        bp_pkg::OPC_JALR:   kind_o = bp_pkg::BR_NONE;
        default:            kind_o = bp_pkg::BR_NONE;
      endcase
    end
  end

endmodule : branch_classifier

/* source/branch_ctrl.sv */
module branch_ctrl (
  input  logic                clk_i,
  input  logic                rst_i,
  input  bp_pkg::br_kind_e    kind_i,
  input  logic                res_vld_i,
  input  logic                res_taken_i,
  input  bp_pkg::pred_entry_t head_i,
  input  logic                empty_i,
  input  logic                full_i,
  output logic                push_o,
  output logic                pop_o,
  output logic                flush_o,
  output bp_pkg::res_event_t  res_o,
  output logic                stall_o,
  output logic                br_instr_o,
  output logic                br_miss_o
);

  bp_pkg::ctrl_state_e state_q;
  bp_pkg::ctrl_state_e state_d;
  logic                miss;

  // Head is the oldest branch, the resolve always refers to it
  assign miss = res_vld_i && !empty_i && (head_i.pred_taken != res_taken_i);

  always_comb begin
    res_o       = '0;
    res_o.br    = res_vld_i;
    res_o.miss  = miss;
    res_o.taken = res_taken_i;
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      bp_pkg::ST_RUN:      if (miss) state_d = bp_pkg::ST_REDIRECT;
      bp_pkg::ST_REDIRECT: state_d = bp_pkg::ST_RUN;  // Single bubble
      default:             state_d = bp_pkg::ST_RUN;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) state_q <= bp_pkg::ST_RUN;
    else       state_q <= state_d;
  end

  assign stall_o = full_i;                     // Level, no handshake
  assign pop_o   = res_vld_i;
  assign flush_o = miss;                       // Kills younger entries and this cycle's push
  assign push_o  = (kind_i != bp_pkg::BR_NONE)
                && (state_q == bp_pkg::ST_RUN)
                && !full_i;

  // Strobes trail the resolve by one cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      br_instr_o <= 1'b0;
      br_miss_o  <= 1'b0;
    end else begin
      br_instr_o <= res_o.br;
      br_miss_o  <= res_o.miss;
    end
  end

  // After a miss the queue is drained and fetch is in its bubble
  a_flush_drains: assert property (@(posedge clk_i) disable iff (rst_i)
    flush_o |=> empty_i && (state_q == bp_pkg::ST_REDIRECT))
    else $error("branch_ctrl: queue not drained after miss");

endmodule : branch_ctrl

/* source/branch_stats.sv */
module branch_stats (
  input  logic               clk_i,
  input  logic               rst_i,
  input  bp_pkg::res_event_t res_i,
  output bp_pkg::stat_t      br_count_o,
  output bp_pkg::stat_t      miss_count_o
);

  logic br_inc;
  logic miss_inc;

  // Hold at the top value instead of wrapping
  assign br_inc   = res_i.br && (br_count_o != '1);
  assign miss_inc = res_i.br && res_i.miss && (miss_count_o != '1);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      br_count_o   <= '0;
      miss_count_o <= '0;
    end else begin
      if (br_inc)   br_count_o   <= br_count_o + 1'b1;  // Every resolve
      if (miss_inc) miss_count_o <= miss_count_o + 1'b1;
    end
  end

endmodule : branch_stats

/* source/inflight_queue.sv */
module inflight_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                push_i,
  input  bp_pkg::pred_entry_t push_entry_i,
  input  logic                pop_i,
  input  logic                flush_i,
  output bp_pkg::pred_entry_t head_o,
  output logic                empty_o,
  output logic                full_o
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(QUEUE_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(QUEUE_DEPTH);

  bp_pkg::pred_entry_t mem_q [QUEUE_DEPTH];
  logic [PTR_W-1:0]    wr_ptr_q;
  logic [PTR_W-1:0]    rd_ptr_q;
  logic [CNT_W-1:0]    cnt_q;    // Occupancy
  logic                do_push;
  logic                do_pop;

  // Wrap also works for depths that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
  endfunction

  assign do_push = push_i && !flush_i;             // Flush wins over everything
  assign do_pop  = pop_i && !flush_i && !empty_o;

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= push_entry_i;  // Payload, no reset
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (do_pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;  // Both or neither
      endcase
    end
  end

  assign head_o  = mem_q[rd_ptr_q];
  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == FULL_CNT);

  // A resolve needs a queued branch
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> !empty_o)
    else $error("inflight_queue: pop while empty");

  // Control must hold fetch while the stall is up
  a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
    push_i |-> !full_o)
    else $error("inflight_queue: push while full");

endmodule : inflight_queue

/* source/pattern_table.sv */
module pattern_table #(
  parameter int IDX_BITS  = 6,
  parameter int HIST_BITS = 4
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  bp_pkg::addr_t       fetch_pc_i,
  input  bp_pkg::br_kind_e    kind_i,
  output bp_pkg::pred_entry_t entry_o,
  input  bp_pkg::res_event_t  upd_i,
  input  logic [15:0]         upd_idx_i,
  input  logic                upd_cond_i
);

  localparam int TBL_SIZE = 1 << IDX_BITS;
  // History occupies the low HIST_BITS of the index, zero width gives bimodal
  localparam logic [IDX_BITS-1:0] HIST_MASK = IDX_BITS'((1 << HIST_BITS) - 1);

  bp_pkg::ctr_t        tbl_q [TBL_SIZE];
  logic [IDX_BITS-1:0] hist_q;     // Newest outcome in bit 0
  logic [IDX_BITS-1:0] fetch_idx;  // gshare index of this fetch
  logic [IDX_BITS-1:0] upd_idx;
  bp_pkg::ctr_t        fetch_ctr;
  bp_pkg::ctr_t        upd_ctr;
  logic                upd_en;

  // PC bits 1:0 are always zero for RV32I without C
  assign fetch_idx = fetch_pc_i[IDX_BITS+1:2] ^ hist_q;
  assign fetch_ctr = tbl_q[fetch_idx];

  always_comb begin
    entry_o            = '0;
    entry_o.is_cond    = (kind_i == bp_pkg::BR_COND);
    entry_o.tbl_idx    = 16'(fetch_idx);
    case (kind_i)
      bp_pkg::BR_JAL:  entry_o.pred_taken = 1'b1;          // Always taken
      bp_pkg::BR_COND: entry_o.pred_taken = fetch_ctr[1];  // Counter MSB
      default:         entry_o.pred_taken = 1'b0;
    endcase
  end

  // Only conditional branches train the table and history
  assign upd_en  = upd_i.br && upd_cond_i;
  assign upd_idx = upd_idx_i[IDX_BITS-1:0];
  assign upd_ctr = tbl_q[upd_idx];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < TBL_SIZE; i++) begin
        tbl_q[i] <= bp_pkg::CTR_INIT;
      end
    end else if (upd_en) begin
      if (upd_i.taken) begin
        if (upd_ctr != bp_pkg::CTR_MAX) tbl_q[upd_idx] <= upd_ctr + 2'd1;  // Saturate up
      end else begin
        if (upd_ctr != bp_pkg::CTR_MIN) tbl_q[upd_idx] <= upd_ctr - 2'd1;  // Saturate down
      end
    end
  end

  // Global history, committed at resolve only
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      hist_q <= '0;
    end else if (upd_en) begin
      hist_q <= IDX_BITS'({hist_q, upd_i.taken}) & HIST_MASK;  // Oldest bit drops off
    end
  end

endmodule : pattern_table

/* test/bp_model.svh */
// Reference model of the predictor slice, stepped once per clock
localparam int TBL_SIZE  = 1 << IDX_BITS;
localparam int HIST_MASK = (1 << HIST_BITS) - 1;  // Zero for bimodal

logic [1:0]          ctr_m [TBL_SIZE];  // Two-bit counters
int                  hist_m;            // Newest outcome in bit 0
bp_pkg::pred_entry_t queue_m [$];       // Oldest first
bit                  redirect_m;        // Bubble cycle after a miss
logic                exp_br;
logic                exp_miss;
logic [15:0]         exp_br_cnt;
logic [15:0]         exp_miss_cnt;
logic [31:0]         exp_instr;

task automatic model_reset();
  foreach (ctr_m[i]) begin
    ctr_m[i] = 2'd1;  // Weakly not taken
  end
  hist_m = 0;
  queue_m.delete();
  redirect_m   = 1'b0;
  exp_br       = 1'b0;
  exp_miss     = 1'b0;
  exp_br_cnt   = '0;
  exp_miss_cnt = '0;
  exp_instr    = '0;
endtask

// 0 none, 1 conditional, 2 JAL
function automatic int model_kind(input logic vld, input logic [31:0] instr);
  if (!vld) return 0;
  if (instr[6:0] == 7'b1100011) return 1;
  return (instr[6:0] == 7'b1101111) ? 2 : 0;  // JALR lands in none
endfunction

function automatic int model_index(input logic [31:0] pc);
  return int'((pc >> 2) & (TBL_SIZE - 1)) ^ hist_m;  // gshare
endfunction

function automatic logic model_pred(input logic vld, input logic [31:0] pc,
                                    input logic [31:0] instr);
  int kind;
  kind = model_kind(vld, instr);
  if (kind == 2) return 1'b1;
  return (kind == 1) ? ctr_m[model_index(pc)][1] : 1'b0;
endfunction

task automatic model_step(input logic vld, input logic [31:0] pc, input logic [31:0] instr,
                          input logic res_vld, input logic res_taken);
  bp_pkg::pred_entry_t entry;
  logic                accept;
  logic                miss;
  int                  idx;
  entry.is_cond    = (model_kind(vld, instr) == 1);
  entry.pred_taken = model_pred(vld, pc, instr);
  entry.tbl_idx    = 16'(model_index(pc));  // Old history and counters
  accept = (model_kind(vld, instr) != 0) && !redirect_m && (queue_m.size() < QUEUE_DEPTH);
  miss   = res_vld && (queue_m[0].pred_taken != res_taken);
  if (res_vld && queue_m[0].is_cond) begin  // JAL trains nothing
    idx = int'(queue_m[0].tbl_idx);
    if (res_taken && ctr_m[idx] != 2'd3) ctr_m[idx]++;
    if (!res_taken && ctr_m[idx] != 2'd0) ctr_m[idx]--;
    hist_m = ((hist_m << 1) | int'(res_taken)) & HIST_MASK;
  end
  if (res_vld && exp_br_cnt != 16'hffff) exp_br_cnt++;
  if (miss && exp_miss_cnt != 16'hffff) exp_miss_cnt++;
  if (miss) begin
    queue_m.delete();  // Younger branches and this fetch are gone
  end else begin
    if (res_vld) void'(queue_m.pop_front());
    if (accept) queue_m.push_back(entry);
  end
  exp_br     = res_vld;
  exp_miss   = miss;
  redirect_m = miss;
  exp_instr  = instr;
endtask

/* test/tb_bp_top.sv */
module tb_bp_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int IDX_BITS    = 6;
  localparam int HIST_BITS   = 4;
  localparam int QUEUE_DEPTH = 4;
  localparam int NUM_CYCLES  = 3000;
  localparam int STALL_LIMIT = 64;  // Resolves drain a full queue well before this

  logic           clk_i;
  logic           rst_i;
  logic           fetch_vld_i;
  bp_pkg::addr_t  fetch_pc_i;
  bp_pkg::instr_t instr_i;
  logic           res_vld_i;
  logic           res_taken_i;
  logic           pred_taken_o;
  logic           stall_o;
  bp_pkg::instr_t instr_o;
  logic           br_instr_o;
  logic           br_miss_o;
  bp_pkg::stat_t  br_count_o;
  bp_pkg::stat_t  miss_count_o;
  integer         seed;
  int             stall_run;  // Consecutive stalled cycles

  `include "bp_model.svh"

  bp_top #(.IDX_BITS(IDX_BITS), .HIST_BITS(HIST_BITS), .QUEUE_DEPTH(QUEUE_DEPTH)) dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;  // 20 ns period
  end

  initial begin
    rst_i = 1'b1;
    repeat (5) @(posedge clk_i);
    #2 rst_i = 1'b0;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      abort_run($sformatf("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, act, exp));
    end
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (rst_i !== 1'b0) begin
      @(negedge clk_i);
      n++;
      if (n > 20) abort_run("Timeout: reset was never released");
    end
  endtask

  task automatic drive_random();
    int op;
    op          = {$random(seed)} % 10;
    fetch_vld_i = ($random(seed) % 5) != 0;  // Mostly fetching
    instr_i     = $random(seed);
    if (op < 5) instr_i[6:0] = 7'b1100011;        // Conditional branch
    else if (op < 7) instr_i[6:0] = 7'b1101111;   // JAL
    else if (op == 7) instr_i[6:0] = 7'b1100111;  // JALR, not a branch here
    else instr_i[6:0] = 7'b0010011;               // ALU immediate
    fetch_pc_i  = 32'h0000_1000 + 32'({$random(seed)} % 12) * 32'd4;  // Small PC pool
    res_vld_i   = (queue_m.size() != 0) && ({$random(seed)} % 4 == 0);
    res_taken_i = ({$random(seed)} % 4) != 0;  // Biased toward taken
  endtask

  initial begin
    seed        = 32'h8fe3d0d8;
    fetch_vld_i = 1'b0;
    fetch_pc_i  = '0;
    instr_i     = '0;
    res_vld_i   = 1'b0;
    res_taken_i = 1'b0;
    stall_run   = 0;
    model_reset();
    wait_reset_release();
    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      @(posedge clk_i);
      #2;
      if (cyc == 0) begin  // Cold conditional branch
        fetch_vld_i = 1'b1;
        fetch_pc_i  = 32'h0000_1000;
        instr_i     = 32'h0000_0063;
        res_vld_i   = 1'b0;
      end else begin
        drive_random();
      end
      #8;  // Mid cycle, outputs settled
      if (cyc == 0) check_eq("pred_taken_o", 32'(pred_taken_o), 32'd0);
      check_eq("pred_taken_o", 32'(pred_taken_o),
               32'(model_pred(fetch_vld_i, fetch_pc_i, instr_i)));
      check_eq("stall_o", 32'(stall_o), 32'(queue_m.size() == QUEUE_DEPTH));
      check_eq("br_instr_o", 32'(br_instr_o), 32'(exp_br));
      check_eq("br_miss_o", 32'(br_miss_o), 32'(exp_miss));
      check_eq("br_count_o", 32'(br_count_o), 32'(exp_br_cnt));
      check_eq("miss_count_o", 32'(miss_count_o), 32'(exp_miss_cnt));
      check_eq("instr_o", instr_o, exp_instr);
      stall_run = stall_o ? stall_run + 1 : 0;
      if (stall_run > STALL_LIMIT) abort_run("Timeout: stall_o stayed high");
      model_step(fetch_vld_i, fetch_pc_i, instr_i, res_vld_i, res_taken_i);  // Coming edge
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule : tb_bp_top
